//--- rtl/roce_cmd_pkg.sv
/*
  Shared widths, word layouts and structs for the RoCE v2 command adapter.
  The layouts mirror the transport engine's flat words bit for bit; a change
  in the engine word format must be made here and nowhere else.
  Packed struct fields are listed MSB first.
  Bits above the last field of the memory-command word are ignored.
*/
package roce_cmd_pkg;

  // Field widths
  localparam int OPCODE_BITS    = 5;
  localparam int PID_BITS       = 6;
  localparam int DEST_BITS      = 4;
  localparam int STRM_BITS      = 2;
  localparam int OFFS_BITS      = 6;
  localparam int VADDR_BITS     = 48;
  localparam int LEN_BITS       = 28;
  localparam int QPN_BITS       = 24;
  localparam int RDMA_LEN_BITS  = 32;
  localparam int RDMA_IMM_BITS  = 32;
  localparam int ECN_BITS       = 1;
  localparam int ACK_RSRVD_BITS = 4;

  // Raw transfer mode for engine-issued memory commands
  localparam logic RDMA_MODE_RAW = 1'b1;

  // Word widths
  localparam int SQ_BITS      = 256;
  localparam int MEM_CMD_BITS = 160;
  localparam int ACK_BITS     = 72;

  // Send-queue word
  localparam int SQ_OPCODE_OFFS = 0;
  localparam int SQ_QPN_OFFS    = 32;
  localparam int SQ_HOST_OFFS   = 56;
  localparam int SQ_LAST_OFFS   = 57;
  localparam int SQ_OFFS_OFFS   = 58;
  localparam int SQ_ADDR1_OFFS  = 64;
  localparam int SQ_ADDR2_OFFS  = 128;
  localparam int SQ_LEN_OFFS    = 192;
  localparam int SQ_IMM_OFFS    = 224;
  // Address slots are wider than vaddr, top is padding
  localparam int SQ_ADDR_BITS   = SQ_ADDR2_OFFS - SQ_ADDR1_OFFS;
  // Part of req_2 offs that fits above req_2 len in the immediate
  localparam int IMM_OFFS_BITS  = RDMA_IMM_BITS - LEN_BITS;

  // Memory-command word
  localparam int MC_OPCODE_OFFS = 0;
  localparam int MC_PID_OFFS    = 32;
  localparam int MC_VFID_OFFS   = 38;
  localparam int MC_LAST_OFFS   = 56;
  localparam int MC_VADDR_OFFS  = 57;
  localparam int MC_DEST_OFFS   = 105;
  localparam int MC_STRM_OFFS   = 109;
  localparam int MC_LEN_OFFS    = 111;
  localparam int MC_ACTV_OFFS   = 139;
  localparam int MC_HOST_OFFS   = 140;
  localparam int MC_OFFS_OFFS   = 141;

  // Acknowledge word
  localparam int ACK_OPCODE_OFFS = 0;
  localparam int ACK_PID_OFFS    = 32;
  localparam int ACK_VFID_OFFS   = 38;
  localparam int ACK_HOST_OFFS   = 56;
  localparam int ACK_DEST_OFFS   = 57;
  localparam int ACK_STRM_OFFS   = 61;
  localparam int ACK_LAST_OFFS   = 63;
  localparam int ACK_ECN_OFFS    = 64;

  typedef logic [SQ_BITS-1:0]      sq_word_t;
  typedef logic [MEM_CMD_BITS-1:0] mem_cmd_word_t;
  typedef logic [ACK_BITS-1:0]     ack_word_t;

  typedef struct packed {
    logic [OPCODE_BITS-1:0] opcode;
    logic                   mode;
    logic                   rdma;
    logic                   remote;
    logic [PID_BITS-1:0]    pid;
    logic [DEST_BITS-1:0]   vfid;
    logic                   last;
    logic [VADDR_BITS-1:0]  vaddr;
    logic [DEST_BITS-1:0]   dest;
    logic [STRM_BITS-1:0]   strm;
    logic [LEN_BITS-1:0]    len;
    logic                   actv;
    logic                   host;
    logic [OFFS_BITS-1:0]   offs;
  } req_t;

  // User send-queue request, two halves
  typedef struct packed {
    req_t req_1;
    req_t req_2;
  } dreq_t;

  typedef struct packed {
    logic [OPCODE_BITS-1:0]    opcode;
    logic                      remote;
    logic [PID_BITS-1:0]       pid;
    logic [DEST_BITS-1:0]      vfid;
    logic                      host;
    logic [DEST_BITS-1:0]      dest;
    logic [STRM_BITS-1:0]      strm;
    logic [ECN_BITS-1:0]       ecn;
    logic [ACK_RSRVD_BITS-1:0] rsrvd;
  } ack_t;

  typedef struct packed {
    ack_t ack;
    logic last;
  } dack_t;

endpackage

//--- rtl/meta_slice.sv
/*
  Two-entry valid/ready register slice: output register plus skid entry.
  One cycle latency, one item per cycle when not stalled.
  in_ready is a flop output; it drops only while both entries are full.
  Payload registers carry no reset, only the valid bits are cleared.
*/
`timescale 1ns/10ps

module meta_slice #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     nclk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     skid_valid;
  payload_t skid_data;
  logic     out_load;
  logic     in_fire;

  // Output register may take a new item this cycle
  assign out_load = ~out_valid | out_ready;
  assign in_fire  = in_valid & in_ready;

  // Skid entry empty means room for at least one more
  assign in_ready = ~skid_valid;

  always_ff @(posedge nclk) begin
    if (reset) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (out_load) begin
        // Skid entry drains first to keep order
        out_valid  <= skid_valid | in_fire;
        skid_valid <= 1'b0;
      end else if (in_fire) begin
        // Output held, park the new item
        skid_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge nclk) begin
    if (out_load) begin
      out_data <= skid_valid ? skid_data : in_data;
    end
    if (~out_load && in_fire) begin
      skid_data <= in_data;
    end
  end

endmodule

//--- rtl/sq_encode.sv
/*
  Send-queue encoder: packs the user request pair into the engine word.
  Only req_1 supplies opcode, queue pair, flags and first address;
  req_2 contributes vaddr, strm, len and the low bits of offs.
  All padding bits are zero. One cycle latency through the slice.
*/
`timescale 1ns/10ps

module sq_encode import roce_cmd_pkg::*; (
  input  logic     nclk,
  input  logic     reset,
  input  logic     req_valid,
  output logic     req_ready,
  input  dreq_t    req,
  output logic     sq_valid,
  input  logic     sq_ready,
  output sq_word_t sq_data
);

  sq_word_t sq_word;

  always_comb begin
    sq_word = '0;

    sq_word[SQ_OPCODE_OFFS +: OPCODE_BITS] = req.req_1.opcode;
    // Queue pair field carries vfid over pid
    sq_word[SQ_QPN_OFFS +: QPN_BITS] =
      {{(QPN_BITS - DEST_BITS - PID_BITS){1'b0}}, req.req_1.vfid, req.req_1.pid};
    sq_word[SQ_HOST_OFFS]                  = req.req_1.host;
    sq_word[SQ_LAST_OFFS]                  = req.req_1.last;
    sq_word[SQ_OFFS_OFFS +: OFFS_BITS]     = req.req_1.offs;

    // First address, zero extended
    sq_word[SQ_ADDR1_OFFS +: SQ_ADDR_BITS] = SQ_ADDR_BITS'(req.req_1.vaddr);
    // Second address slot also holds req_1 dest and req_2 strm
    sq_word[SQ_ADDR2_OFFS +: SQ_ADDR_BITS] =
      SQ_ADDR_BITS'({req.req_2.strm, req.req_1.dest, req.req_2.vaddr});

    sq_word[SQ_LEN_OFFS +: RDMA_LEN_BITS]  = RDMA_LEN_BITS'(req.req_1.len);
    // Immediate, offs truncated to what is left above len
    sq_word[SQ_IMM_OFFS +: RDMA_IMM_BITS]  =
      {req.req_2.offs[IMM_OFFS_BITS-1:0], req.req_2.len};
  end

  meta_slice #(
    .payload_t (sq_word_t)
  ) i_slice (
    .nclk      (nclk),
    .reset     (reset),
    .in_valid  (req_valid),
    .in_ready  (req_ready),
    .in_data   (sq_word),
    .out_valid (sq_valid),
    .out_ready (sq_ready),
    .out_data  (sq_data)
  );

endmodule

//--- rtl/mem_cmd_decode.sv
/*
  Memory-command decoder for engine read or write commands.
  Engine commands are always raw RDMA requests toward local memory,
  so mode, rdma and remote are constants. Unused word bits are ignored.
  One cycle latency through the slice.
*/
`timescale 1ns/10ps

module mem_cmd_decode import roce_cmd_pkg::*; (
  input  logic          nclk,
  input  logic          reset,
  input  logic          cmd_valid,
  output logic          cmd_ready,
  input  mem_cmd_word_t cmd_data,
  output logic          req_valid,
  input  logic          req_ready,
  output req_t          req
);

  req_t cmd_req;

  always_comb begin
    // Fixed fields
    cmd_req.mode   = RDMA_MODE_RAW;
    cmd_req.rdma   = 1'b1;
    cmd_req.remote = 1'b0;

    // Queue pair part
    cmd_req.opcode = cmd_data[MC_OPCODE_OFFS +: OPCODE_BITS];
    cmd_req.pid    = cmd_data[MC_PID_OFFS +: PID_BITS];
    cmd_req.vfid   = cmd_data[MC_VFID_OFFS +: DEST_BITS];

    // Transfer part
    cmd_req.last   = cmd_data[MC_LAST_OFFS];
    cmd_req.vaddr  = cmd_data[MC_VADDR_OFFS +: VADDR_BITS];
    cmd_req.dest   = cmd_data[MC_DEST_OFFS +: DEST_BITS];
    cmd_req.strm   = cmd_data[MC_STRM_OFFS +: STRM_BITS];
    cmd_req.len    = cmd_data[MC_LEN_OFFS +: LEN_BITS];
    cmd_req.actv   = cmd_data[MC_ACTV_OFFS];
    cmd_req.host   = cmd_data[MC_HOST_OFFS];
    cmd_req.offs   = cmd_data[MC_OFFS_OFFS +: OFFS_BITS];
  end

  meta_slice #(
    .payload_t (req_t)
  ) i_slice (
    .nclk      (nclk),
    .reset     (reset),
    .in_valid  (cmd_valid),
    .in_ready  (cmd_ready),
    .in_data   (cmd_req),
    .out_valid (req_valid),
    .out_ready (req_ready),
    .out_data  (req)
  );

endmodule

//--- rtl/ack_decode.sv
/*
  Acknowledge decoder for the engine's received-ack word.
  Acks from the engine always come from the remote side; rsrvd is zero.
  Upper word bits past ecn are ignored. One cycle latency.
*/
`timescale 1ns/10ps

module ack_decode import roce_cmd_pkg::*; (
  input  logic      nclk,
  input  logic      reset,
  input  logic      word_valid,
  output logic      word_ready,
  input  ack_word_t word_data,
  output logic      ack_valid,
  input  logic      ack_ready,
  output dack_t     ack
);

  dack_t word_ack;

  always_comb begin
    word_ack.ack.opcode = word_data[ACK_OPCODE_OFFS +: OPCODE_BITS];
    word_ack.ack.remote = 1'b1;
    word_ack.ack.pid    = word_data[ACK_PID_OFFS +: PID_BITS];
    word_ack.ack.vfid   = word_data[ACK_VFID_OFFS +: DEST_BITS];
    word_ack.ack.host   = word_data[ACK_HOST_OFFS];
    word_ack.ack.dest   = word_data[ACK_DEST_OFFS +: DEST_BITS];
    word_ack.ack.strm   = word_data[ACK_STRM_OFFS +: STRM_BITS];
    // Congestion mark from the engine
    word_ack.ack.ecn    = word_data[ACK_ECN_OFFS +: ECN_BITS];
    word_ack.ack.rsrvd  = '0;
    word_ack.last       = word_data[ACK_LAST_OFFS];
  end

  meta_slice #(
    .payload_t (dack_t)
  ) i_slice (
    .nclk      (nclk),
    .reset     (reset),
    .in_valid  (word_valid),
    .in_ready  (word_ready),
    .in_data   (word_ack),
    .out_valid (ack_valid),
    .out_ready (ack_ready),
    .out_data  (ack)
  );

endmodule

//--- rtl/roce_cmd_adapter.sv
/*
  Command adapter between user logic and the RoCE v2 transport engine.
  Four independent valid/ready paths, each one registered slice deep:
  user send queue to engine, engine read and write memory commands to
  memory requests, engine acks to user acks.
  Synchronous active-high reset clears all items in flight.
  Each path holds at most two items before its input ready drops.
*/
`timescale 1ns/10ps

module roce_cmd_adapter import roce_cmd_pkg::*; (
  input  logic          nclk,
  input  logic          reset,

  // User send queue in
  input  logic          sq_valid,
  output logic          sq_ready,
  input  dreq_t         sq_req,

  // Send queue toward the engine
  output logic          eng_sq_valid,
  input  logic          eng_sq_ready,
  output sq_word_t      eng_sq_data,

  // Engine read commands
  input  logic          eng_rd_cmd_valid,
  output logic          eng_rd_cmd_ready,
  input  mem_cmd_word_t eng_rd_cmd_data,

  // Read requests to memory
  output logic          rd_req_valid,
  input  logic          rd_req_ready,
  output req_t          rd_req,

  // Engine write commands
  input  logic          eng_wr_cmd_valid,
  output logic          eng_wr_cmd_ready,
  input  mem_cmd_word_t eng_wr_cmd_data,

  // Write requests to memory
  output logic          wr_req_valid,
  input  logic          wr_req_ready,
  output req_t          wr_req,

  // Engine acks
  input  logic          eng_ack_valid,
  output logic          eng_ack_ready,
  input  ack_word_t     eng_ack_data,

  // Acks to user logic
  output logic          ack_valid,
  input  logic          ack_ready,
  output dack_t         ack
);

  // Request side
  sq_encode i_sq_encode (
    .nclk      (nclk),
    .reset     (reset),
    .req_valid (sq_valid),
    .req_ready (sq_ready),
    .req       (sq_req),
    .sq_valid  (eng_sq_valid),
    .sq_ready  (eng_sq_ready),
    .sq_data   (eng_sq_data)
  );

  // Engine command side, same decoder for reads and writes
  mem_cmd_decode i_rd_decode (
    .nclk      (nclk),
    .reset     (reset),
    .cmd_valid (eng_rd_cmd_valid),
    .cmd_ready (eng_rd_cmd_ready),
    .cmd_data  (eng_rd_cmd_data),
    .req_valid (rd_req_valid),
    .req_ready (rd_req_ready),
    .req       (rd_req)
  );

  mem_cmd_decode i_wr_decode (
    .nclk      (nclk),
    .reset     (reset),
    .cmd_valid (eng_wr_cmd_valid),
    .cmd_ready (eng_wr_cmd_ready),
    .cmd_data  (eng_wr_cmd_data),
    .req_valid (wr_req_valid),
    .req_ready (wr_req_ready),
    .req       (wr_req)
  );

  // Result side
  ack_decode i_ack_decode (
    .nclk       (nclk),
    .reset      (reset),
    .word_valid (eng_ack_valid),
    .word_ready (eng_ack_ready),
    .word_data  (eng_ack_data),
    .ack_valid  (ack_valid),
    .ack_ready  (ack_ready),
    .ack        (ack)
  );

endmodule

//--- verif/roce_cmd_adapter_properties.sv
/*
  Handshake rules on the four adapter paths, bound into roce_cmd_adapter.
  Stall and latency rules are off while reset is high.
  Latency rule only covers items that enter an empty path.
*/
`timescale 1ns/10ps

module roce_cmd_adapter_properties import roce_cmd_pkg::*; (
  input logic     nclk,
  input logic     reset,
  input logic     sq_valid,
  input logic     sq_ready,
  input logic     eng_sq_valid,
  input logic     eng_sq_ready,
  input sq_word_t eng_sq_data,
  input logic     eng_rd_cmd_valid,
  input logic     eng_rd_cmd_ready,
  input logic     rd_req_valid,
  input logic     rd_req_ready,
  input req_t     rd_req,
  input logic     eng_wr_cmd_valid,
  input logic     eng_wr_cmd_ready,
  input logic     wr_req_valid,
  input logic     wr_req_ready,
  input req_t     wr_req,
  input logic     eng_ack_valid,
  input logic     eng_ack_ready,
  input logic     ack_valid,
  input logic     ack_ready,
  input dack_t    ack
);

  // Held outputs keep valid and data
  sq_hold: assert property (@(posedge nclk) disable iff (reset)
    eng_sq_valid && !eng_sq_ready |=> eng_sq_valid && $stable(eng_sq_data))
    else $error("eng_sq output changed while stalled");
  rd_hold: assert property (@(posedge nclk) disable iff (reset)
    rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req))
    else $error("rd_req output changed while stalled");
  wr_hold: assert property (@(posedge nclk) disable iff (reset)
    wr_req_valid && !wr_req_ready |=> wr_req_valid && $stable(wr_req))
    else $error("wr_req output changed while stalled");
  ack_hold: assert property (@(posedge nclk) disable iff (reset)
    ack_valid && !ack_ready |=> ack_valid && $stable(ack))
    else $error("ack output changed while stalled");

  // First cycle out of reset
  reset_clear: assert property (@(posedge nclk)
    $fell(reset) |-> !eng_sq_valid && !rd_req_valid && !wr_req_valid && !ack_valid)
    else $error("output valid high right after reset");

  // Empty path, one cycle latency
  sq_rise: assert property (@(posedge nclk) disable iff (reset)
    sq_valid && sq_ready && !eng_sq_valid |=> eng_sq_valid)
    else $error("eng_sq_valid late after accepted request");
  rd_rise: assert property (@(posedge nclk) disable iff (reset)
    eng_rd_cmd_valid && eng_rd_cmd_ready && !rd_req_valid |=> rd_req_valid)
    else $error("rd_req_valid late after accepted command");
  wr_rise: assert property (@(posedge nclk) disable iff (reset)
    eng_wr_cmd_valid && eng_wr_cmd_ready && !wr_req_valid |=> wr_req_valid)
    else $error("wr_req_valid late after accepted command");
  ack_rise: assert property (@(posedge nclk) disable iff (reset)
    eng_ack_valid && eng_ack_ready && !ack_valid |=> ack_valid)
    else $error("ack_valid late after accepted ack word");

endmodule

bind roce_cmd_adapter roce_cmd_adapter_properties i_properties (.*);

//--- verif/tb_roce_cmd_adapter.sv
/*
  Random traffic on all four adapter paths with output stalls, a reset in
  mid run, a back-to-back phase and a final drain.
  Expected send-queue words come from the field layouts.
  Decoder input words are built from random fields that are also the expected outputs.
  Handshakes and outputs are sampled on the falling clock edge.
*/
`timescale 1ns/10ps

module tb_roce_cmd_adapter import roce_cmd_pkg::*; ();

  localparam int ITEMS   = 200;
  localparam int TOTAL   = 4 * ITEMS;
  localparam int MAX_CYC = 4 * TOTAL + 200;

  logic          nclk;
  logic          reset;
  logic          sq_valid;
  logic          sq_ready;
  dreq_t         sq_req;
  logic          eng_sq_valid;
  logic          eng_sq_ready;
  sq_word_t      eng_sq_data;
  logic          eng_rd_cmd_valid;
  logic          eng_rd_cmd_ready;
  mem_cmd_word_t eng_rd_cmd_data;
  logic          rd_req_valid;
  logic          rd_req_ready;
  req_t          rd_req;
  logic          eng_wr_cmd_valid;
  logic          eng_wr_cmd_ready;
  mem_cmd_word_t eng_wr_cmd_data;
  logic          wr_req_valid;
  logic          wr_req_ready;
  req_t          wr_req;
  logic          eng_ack_valid;
  logic          eng_ack_ready;
  ack_word_t     eng_ack_data;
  logic          ack_valid;
  logic          ack_ready;
  dack_t         ack;

  // Expected outputs in one queue per path
  sq_word_t sq_q[$];
  req_t     rd_q[$];
  req_t     wr_q[$];
  dack_t    ack_q[$];

  // Expected output for the word each engine source holds
  req_t     rd_exp;
  req_t     wr_exp;
  dack_t    ack_exp;

  integer seed = 32'hdd24;
  logic   sq_fire;
  logic   rd_fire;
  logic   wr_fire;
  logic   ack_fire;
  int     done_sq;
  int     done_rd;
  int     done_wr;
  int     done_ack;
  int     data_errors;
  int     proto_errors;
  int     cycles = 0;
  // Phase is 0 for random, 1 for back to back and 2 for drain
  int     phase = 0;
  int     tput_cycle = 0;

  roce_cmd_adapter i_roce_cmd_adapter (.*);

  initial begin
    nclk = 1'b0;
    forever #2 nclk = ~nclk;
  end

  function automatic logic [255:0] rand_bits();
    rand_bits = {$random(seed), $random(seed), $random(seed), $random(seed),
                 $random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic logic chance(int unsigned pct);
    chance = ({$random(seed)} % 32'd100) < pct;
  endfunction

  // Send-queue layout built one field at a time
  function automatic sq_word_t pack_sq(dreq_t r);
    sq_word_t w;
    w = '0;
    w[SQ_OPCODE_OFFS +: OPCODE_BITS] = r.req_1.opcode;
    w[SQ_QPN_OFFS +: PID_BITS] = r.req_1.pid;
    w[SQ_QPN_OFFS + PID_BITS +: DEST_BITS] = r.req_1.vfid;
    w[SQ_HOST_OFFS] = r.req_1.host;
    w[SQ_LAST_OFFS] = r.req_1.last;
    w[SQ_OFFS_OFFS +: OFFS_BITS] = r.req_1.offs;
    w[SQ_ADDR1_OFFS +: VADDR_BITS] = r.req_1.vaddr;
    w[SQ_ADDR2_OFFS +: VADDR_BITS] = r.req_2.vaddr;
    w[SQ_ADDR2_OFFS + VADDR_BITS +: DEST_BITS] = r.req_1.dest;
    w[SQ_ADDR2_OFFS + VADDR_BITS + DEST_BITS +: STRM_BITS] = r.req_2.strm;
    w[SQ_LEN_OFFS +: LEN_BITS] = r.req_1.len;
    w[SQ_IMM_OFFS +: LEN_BITS] = r.req_2.len;
    // Only the low offs bits fit in the immediate
    w[SQ_IMM_OFFS + LEN_BITS +: IMM_OFFS_BITS] = r.req_2.offs[IMM_OFFS_BITS-1:0];
    return w;
  endfunction

  // Engine commands always become raw RDMA requests toward local memory
  function automatic req_t expected_req(req_t r);
    r.mode   = RDMA_MODE_RAW;
    r.rdma   = 1'b1;
    r.remote = 1'b0;
    return r;
  endfunction

  // Engine acks are remote with the reserved bits clear
  function automatic dack_t expected_ack(dack_t a);
    a.ack.remote = 1'b1;
    a.ack.rsrvd  = '0;
    return a;
  endfunction

  // Memory-command fields placed over random filler in the unused bits
  function automatic mem_cmd_word_t encode_cmd_word(req_t r, mem_cmd_word_t fill);
    mem_cmd_word_t c;
    c = fill;
    c[MC_OPCODE_OFFS +: OPCODE_BITS] = r.opcode;
    c[MC_PID_OFFS +: PID_BITS]       = r.pid;
    c[MC_VFID_OFFS +: DEST_BITS]     = r.vfid;
    c[MC_LAST_OFFS]                  = r.last;
    c[MC_VADDR_OFFS +: VADDR_BITS]   = r.vaddr;
    c[MC_DEST_OFFS +: DEST_BITS]     = r.dest;
    c[MC_STRM_OFFS +: STRM_BITS]     = r.strm;
    c[MC_LEN_OFFS +: LEN_BITS]       = r.len;
    c[MC_ACTV_OFFS]                  = r.actv;
    c[MC_HOST_OFFS]                  = r.host;
    c[MC_OFFS_OFFS +: OFFS_BITS]     = r.offs;
    return c;
  endfunction

  // Acknowledge fields placed over random filler
  function automatic ack_word_t encode_ack_word(dack_t a, ack_word_t fill);
    ack_word_t w;
    w = fill;
    w[ACK_OPCODE_OFFS +: OPCODE_BITS] = a.ack.opcode;
    w[ACK_PID_OFFS +: PID_BITS]       = a.ack.pid;
    w[ACK_VFID_OFFS +: DEST_BITS]     = a.ack.vfid;
    w[ACK_HOST_OFFS]                  = a.ack.host;
    w[ACK_DEST_OFFS +: DEST_BITS]     = a.ack.dest;
    w[ACK_STRM_OFFS +: STRM_BITS]     = a.ack.strm;
    w[ACK_LAST_OFFS]                  = a.last;
    w[ACK_ECN_OFFS +: ECN_BITS]       = a.ack.ecn;
    return w;
  endfunction

  function automatic void report_mismatch(string name, logic [255:0] exp, logic [255:0] got);
    data_errors++;
    $display("** Error at %0t: %s expected %h actual %h", $time, name, exp, got);
  endfunction

  function automatic void protocol_error(string what);
    proto_errors++;
    $display("Handshake failure at %0t: %s", $time, what);
  endfunction

  // Slice holds two items at most and drops ready only when full
  function automatic void check_occupancy(string name, int held, logic in_rdy, logic out_vld);
    assert (in_rdy == (held < 2))
      else protocol_error($sformatf("%s input ready %b with %0d held", name, in_rdy, held));
    assert (out_vld == (held > 0))
      else protocol_error($sformatf("%s output valid %b with %0d held", name, out_vld, held));
  endfunction

  function automatic int min_done();
    int m;
    m = done_sq;
    if (done_rd < m) begin
      m = done_rd;
    end
    if (done_wr < m) begin
      m = done_wr;
    end
    if (done_ack < m) begin
      m = done_ack;
    end
    return m;
  endfunction

  function automatic logic next_valid();
    next_valid = (phase == 1) || (phase == 0 && chance(70));
  endfunction

  function automatic logic next_ready();
    next_ready = (phase != 0) || chance(60);
  endfunction

  // New item only once the previous one was taken
  task automatic drive_inputs();
    logic [255:0] bits;
    logic [255:0] fill;
    bits = rand_bits();
    if (!sq_valid || sq_fire) begin
      sq_valid = next_valid();
      sq_req   = bits[$bits(dreq_t)-1:0];
    end
    // Random fields first, then the word that carries them
    bits = rand_bits();
    fill = rand_bits();
    if (!eng_rd_cmd_valid || rd_fire) begin
      eng_rd_cmd_valid = next_valid();
      rd_exp           = expected_req(bits[$bits(req_t)-1:0]);
      eng_rd_cmd_data  = encode_cmd_word(rd_exp, fill[MEM_CMD_BITS-1:0]);
    end
    bits = rand_bits();
    fill = rand_bits();
    if (!eng_wr_cmd_valid || wr_fire) begin
      eng_wr_cmd_valid = next_valid();
      wr_exp           = expected_req(bits[$bits(req_t)-1:0]);
      eng_wr_cmd_data  = encode_cmd_word(wr_exp, fill[MEM_CMD_BITS-1:0]);
    end
    bits = rand_bits();
    fill = rand_bits();
    if (!eng_ack_valid || ack_fire) begin
      eng_ack_valid = next_valid();
      ack_exp       = expected_ack(bits[$bits(dack_t)-1:0]);
      eng_ack_data  = encode_ack_word(ack_exp, fill[ACK_BITS-1:0]);
    end
    eng_sq_ready = next_ready();
    rd_req_ready = next_ready();
    wr_req_ready = next_ready();
    ack_ready    = next_ready();
  endtask

  task automatic step();
    drive_inputs();
    @(posedge nclk);
    #1;
  endtask

  task automatic apply_reset(int n);
    reset            = 1'b1;
    sq_valid         = 1'b0;
    eng_rd_cmd_valid = 1'b0;
    eng_wr_cmd_valid = 1'b0;
    eng_ack_valid    = 1'b0;
    repeat (n) @(posedge nclk);
    #1;
    reset = 1'b0;
  endtask

  task automatic finish_run(logic timed_out);
    $display("Errors: data %0d, handshake %0d, timeout %0d", data_errors, proto_errors,
             timed_out);
    if (!timed_out && data_errors == 0 && proto_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  // Scoreboard and handshake checks once per cycle on the falling edge
  always @(negedge nclk) begin
    if (reset) begin
      sq_q.delete();
      rd_q.delete();
      wr_q.delete();
      ack_q.delete();
      {sq_fire, rd_fire, wr_fire, ack_fire} = '0;
    end else begin
      check_occupancy("sq", sq_q.size(), sq_ready, eng_sq_valid);
      check_occupancy("rd", rd_q.size(), eng_rd_cmd_ready, rd_req_valid);
      check_occupancy("wr", wr_q.size(), eng_wr_cmd_ready, wr_req_valid);
      check_occupancy("ack", ack_q.size(), eng_ack_ready, ack_valid);
      if (phase == 1 && tput_cycle >= 2) begin
        assert (sq_ready && eng_sq_valid && eng_rd_cmd_ready && rd_req_valid &&
                eng_wr_cmd_ready && wr_req_valid && eng_ack_ready && ack_valid)
          else protocol_error("a path stopped streaming with all outputs ready");
      end
      // Outputs leave before this cycle's inputs are queued
      if (eng_sq_valid && eng_sq_ready) begin
        assert (eng_sq_data == sq_q[0])
          else report_mismatch("eng_sq_data", sq_q[0], eng_sq_data);
        void'(sq_q.pop_front());
        done_sq++;
      end
      if (rd_req_valid && rd_req_ready) begin
        assert (rd_req == rd_q[0]) else report_mismatch("rd_req", 256'(rd_q[0]), 256'(rd_req));
        void'(rd_q.pop_front());
        done_rd++;
      end
      if (wr_req_valid && wr_req_ready) begin
        assert (wr_req == wr_q[0]) else report_mismatch("wr_req", 256'(wr_q[0]), 256'(wr_req));
        void'(wr_q.pop_front());
        done_wr++;
      end
      if (ack_valid && ack_ready) begin
        assert (ack == ack_q[0]) else report_mismatch("ack", 256'(ack_q[0]), 256'(ack));
        void'(ack_q.pop_front());
        done_ack++;
      end
      sq_fire  = sq_valid && sq_ready;
      rd_fire  = eng_rd_cmd_valid && eng_rd_cmd_ready;
      wr_fire  = eng_wr_cmd_valid && eng_wr_cmd_ready;
      ack_fire = eng_ack_valid && eng_ack_ready;
      if (sq_fire) begin
        sq_q.push_back(pack_sq(sq_req));
      end
      if (rd_fire) begin
        rd_q.push_back(rd_exp);
      end
      if (wr_fire) begin
        wr_q.push_back(wr_exp);
      end
      if (ack_fire) begin
        ack_q.push_back(ack_exp);
      end
    end
  end

  initial begin
    while (cycles < MAX_CYC) begin
      @(posedge nclk);
      cycles++;
    end
    $display("Run stopped after %0d cycles, paths did not drain", cycles);
    finish_run(1'b1);
  end

  initial begin
    {sq_req, eng_rd_cmd_data, eng_wr_cmd_data, eng_ack_data} = '0;
    {eng_sq_ready, rd_req_ready, wr_req_ready, ack_ready} = '0;
    {sq_fire, rd_fire, wr_fire, ack_fire} = '0;
    {done_sq, done_rd, done_wr, done_ack} = '0;
    data_errors  = 0;
    proto_errors = 0;
    apply_reset(16);
    // Random traffic and stalls up to half way
    while (min_done() < ITEMS / 2) begin
      step();
    end
    // Items in flight are dropped and the queues flushed with them
    apply_reset(3);
    phase = 1;
    repeat (32) begin
      tput_cycle++;
      step();
    end
    phase      = 0;
    tput_cycle = 0;
    while (min_done() < ITEMS) begin
      step();
    end
    // Sources stop while outputs stay ready until all paths are empty
    phase = 2;
    while (sq_q.size() + rd_q.size() + wr_q.size() + ack_q.size() > 0 ||
           sq_valid || eng_rd_cmd_valid || eng_wr_cmd_valid || eng_ack_valid) begin
      step();
    end
    finish_run(1'b0);
  end

endmodule

//--- compile.f
rtl/roce_cmd_pkg.sv
rtl/meta_slice.sv
rtl/sq_encode.sv
rtl/mem_cmd_decode.sv
rtl/ack_decode.sv
rtl/roce_cmd_adapter.sv
verif/roce_cmd_adapter_properties.sv
verif/tb_roce_cmd_adapter.sv

//--- Makefile
TOOL     = verilator
TOP      = tb_roce_cmd_adapter
FILELIST = compile.f
FLAGS    = --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Simulation finished: FAIL
PASS_MSG = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Run failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
